/* sim.f */
source/axi_rd_pkg.sv
source/ar_channel.sv
source/beat_addr_gen.sv
source/r_beat_writer.sv
source/local_byte_ram.sv
source/axi_read_master.sv
tb/axi_read_checker.sv
tb/tb_axi_read_master.sv

/* Bender.yml */
package:
  name: axi_read_master

sources:
  - source/axi_rd_pkg.sv
  - source/ar_channel.sv
  - source/beat_addr_gen.sv
  - source/r_beat_writer.sv
  - source/local_byte_ram.sv
  - source/axi_read_master.sv
  - target: simulation
    files:
      - tb/axi_read_checker.sv
      - tb/tb_axi_read_master.sv

/* tb/tb_axi_read_master.sv */
`default_nettype none

module tb_axi_read_master;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DATA_WIDTH = axi_rd_pkg::DEF_DATA_WIDTH;
	localparam int MEM_BYTES  = axi_rd_pkg::DEF_MEM_BYTES;
	localparam int MEM_AW     = $clog2(MEM_BYTES);
	localparam int TIMEOUT    = 200;

	logic                                clk;
	logic                                resetn;
	logic                                cmd_valid;
	logic                                cmd_ready;
	logic [axi_rd_pkg::ADDR_WIDTH-1:0]   cmd_addr;
	logic [axi_rd_pkg::ID_WIDTH-1:0]     cmd_id;
	logic [axi_rd_pkg::LEN_WIDTH-1:0]    cmd_len;
	logic [axi_rd_pkg::SIZE_WIDTH-1:0]   cmd_size;
	axi_rd_pkg::burst_e                  cmd_burst;
	logic                                done;
	logic                                arvalid;
	logic                                arready;
	logic [axi_rd_pkg::ADDR_WIDTH-1:0]   araddr;
	logic [axi_rd_pkg::ID_WIDTH-1:0]     arid;
	logic [axi_rd_pkg::LEN_WIDTH-1:0]    arlen;
	logic [axi_rd_pkg::SIZE_WIDTH-1:0]   arsize;
	axi_rd_pkg::burst_e                  arburst;
	logic                                rvalid;
	logic                                rready;
	logic [DATA_WIDTH-1:0]               rdata;
	logic                                rlast;
	logic [MEM_AW-1:0]                   mem_rd_addr;
	logic [7:0]                          mem_rd_data;

	int         errors = 0;
	int         checks = 0;
	int         done_count = 0;
	integer     seed = 32'h0a49_7522;
	logic [7:0] model_mem [MEM_BYTES];
	bit         written [MEM_BYTES];

	axi_read_master #(
		.DATA_WIDTH (DATA_WIDTH),
		.MEM_BYTES  (MEM_BYTES)
	) uut (.*);

	bind axi_read_master axi_read_checker u_checker (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		if (done)
			done_count <= done_count + 1;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic stop_on_timeout(input string what);
		errors++;
		$display("Timeout while waiting for %s", what);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		$display("Errors found");
		$finish;
	endtask

	// WRAP stays inside the block of (beats x bytes) around the start
	function automatic int beat_address(input int start, input int n, input int size,
			input int len, input axi_rd_pkg::burst_e burst);
		int bytes;
		int span;
		int lower;
		bytes = 1 << size;
		span  = (len + 1) * bytes;
		lower = start - (start % span);
		case (burst)
			axi_rd_pkg::FIXED: return start;
			axi_rd_pkg::WRAP:  return lower + ((start - lower + n * bytes) % span);
			default:           return start + n * bytes;
		endcase
	endfunction

	function automatic int random_len(input axi_rd_pkg::burst_e burst);
		if (burst == axi_rd_pkg::WRAP)
			return (2 << ($unsigned($random(seed)) % 4)) - 1;
		return $unsigned($random(seed)) % 16;
	endfunction

	task automatic run_burst(input int addr, input int len, input int size,
			input axi_rd_pkg::burst_e burst);
		int         wait_cnt;
		int         delay;
		int         beat;
		int         a;
		logic [3:0] id;
		id = 4'($random(seed));
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd_addr  <= 32'(addr);
		cmd_id    <= id;
		cmd_len   <= 4'(len);
		cmd_size  <= 3'(size);
		cmd_burst <= burst;
		wait_cnt = 0;
		do begin
			@(posedge clk);
			wait_cnt++;
			if (wait_cnt > TIMEOUT)
				stop_on_timeout("cmd_ready");
		end while (!cmd_ready);
		cmd_valid <= 1'b0;
		// Slave side of AR with a random stall
		delay = $unsigned($random(seed)) % 4;
		wait_cnt = 0;
		do begin
			@(posedge clk);
			wait_cnt++;
			if (wait_cnt > TIMEOUT)
				stop_on_timeout("the AR handshake");
			if (arvalid && !arready) begin
				if (delay == 0)
					arready <= 1'b1;
				else
					delay--;
			end
		end while (!(arvalid && arready));
		arready <= 1'b0;
		check_value("araddr", addr, araddr);
		check_value("arid", id, arid);
		check_value("arlen", len, arlen);
		check_value("arsize", size, arsize);
		check_value("arburst", burst, arburst);
		beat = 0;
		wait_cnt = 0;
		while (beat <= len) begin
			@(posedge clk);
			wait_cnt++;
			if (wait_cnt > TIMEOUT)
				stop_on_timeout("the read data beats");
			if (rvalid && rready) begin
				a = beat_address(addr, beat, size, len, burst);
				for (int i = 0; i < (1 << size); i++) begin
					model_mem[(a + i) % MEM_BYTES] = rdata[8*i +: 8];
					written[(a + i) % MEM_BYTES] = 1'b1;
				end
				beat++;
			end
			// A beat on offer holds until it is taken
			if (!rvalid || rready) begin
				if (beat <= len && $unsigned($random(seed)) % 4 != 0) begin
					rvalid <= 1'b1;
					rdata  <= $random(seed);
					rlast  <= (beat == len);
				end else begin
					rvalid <= 1'b0;
					rlast  <= 1'b0;
				end
			end
		end
		wait_cnt = 0;
		do begin
			@(posedge clk);
			wait_cnt++;
			if (wait_cnt > TIMEOUT)
				stop_on_timeout("done");
		end while (!done);
		check_value("cmd_ready_at_done", 1, cmd_ready);
	endtask

	// Legal start address with WRAP starting in the middle of its block
	task automatic run_command(input int size, input int len, input axi_rd_pkg::burst_e burst);
		int span;
		int addr;
		span = (len + 1) << size;
		if (burst == axi_rd_pkg::WRAP)
			addr = ($unsigned($random(seed)) % (MEM_BYTES / span)) * span + span / 2;
		else
			addr = ($unsigned($random(seed)) % (MEM_BYTES - span)) & ~((1 << size) - 1);
		run_burst(addr, len, size, burst);
	endtask

	task automatic check_memory(input string name);
		for (int a = 0; a < MEM_BYTES; a++) begin
			if (written[a]) begin
				@(posedge clk);
				mem_rd_addr <= MEM_AW'(a);
				@(posedge clk);
				@(posedge clk);
				check_value($sformatf("%s byte %0h", name, a), model_mem[a], mem_rd_data);
			end
		end
	endtask

	initial begin
		int                 done_before;
		axi_rd_pkg::burst_e burst;
		resetn      = 1'b0;
		cmd_valid   = 1'b0;
		cmd_addr    = '0;
		cmd_id      = '0;
		cmd_len     = '0;
		cmd_size    = '0;
		cmd_burst   = axi_rd_pkg::INCR;
		arready     = 1'b0;
		rvalid      = 1'b0;
		rdata       = '0;
		rlast       = 1'b0;
		mem_rd_addr = '0;
		repeat (4) @(posedge clk);
		resetn <= 1'b1;
		@(posedge clk);
		check_value("reset_cmd_ready", 1, cmd_ready);
		check_value("reset_arvalid", 0, arvalid);
		check_value("reset_rready", 0, rready);
		check_value("reset_done", 0, done);

		for (int s = 0; s < 3; s++) begin
			repeat (4)
				run_command(s, random_len(axi_rd_pkg::INCR), axi_rd_pkg::INCR);
		end
		check_memory("incr");

		for (int s = 0; s < 3; s++) begin
			repeat (2)
				run_command(s, random_len(axi_rd_pkg::FIXED), axi_rd_pkg::FIXED);
		end
		check_memory("fixed");

		for (int k = 0; k < 4; k++) begin
			for (int s = 0; s < 3; s++)
				run_command(s, (2 << k) - 1, axi_rd_pkg::WRAP);
		end
		check_memory("wrap");

		done_before = done_count;
		repeat (40) begin
			burst = axi_rd_pkg::burst_e'($unsigned($random(seed)) % 3);
			run_command($unsigned($random(seed)) % 3, random_len(burst), burst);
		end
		check_memory("mixed");
		check_value("done_count", 40, done_count - done_before);

		errors += uut.u_checker.assert_fails;
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/axi_read_checker.sv */
`default_nettype none

module axi_read_checker (
	input wire                                 clk,
	input wire                                 resetn,
	input wire                                 cmd_ready,
	input wire                                 done,
	input wire                                 arvalid,
	input wire                                 arready,
	input wire [axi_rd_pkg::ADDR_WIDTH-1:0]    araddr,
	input wire [axi_rd_pkg::ID_WIDTH-1:0]      arid,
	input wire [axi_rd_pkg::LEN_WIDTH-1:0]     arlen,
	input wire [axi_rd_pkg::SIZE_WIDTH-1:0]    arsize,
	input wire [1:0]                           arburst,
	input wire                                 rready
);

	timeunit 1ns;
	timeprecision 100ps;

	int assert_fails = 0;

	// AR payload frozen while the slave stalls
	a_ar_stable: assert property (@(posedge clk) disable iff (!resetn)
		arvalid && !arready |=> arvalid && $stable({araddr, arid, arlen, arsize, arburst}))
		else begin
			$error("AR channel changed before arready");
			assert_fails++;
		end

	a_rready_idle: assert property (@(posedge clk) disable iff (!resetn)
		cmd_ready |-> !rready)
		else begin
			$error("rready high while the master is idle");
			assert_fails++;
		end

	a_reset_quiet: assert property (@(posedge clk)
		!resetn |-> !arvalid && !rready && !done)
		else begin
			$error("arvalid, rready or done high during reset");
			assert_fails++;
		end

endmodule

`default_nettype wire

/* source/axi_read_master.sv */
`default_nettype none

module axi_read_master #(
	parameter int DATA_WIDTH = axi_rd_pkg::DEF_DATA_WIDTH,
	parameter int MEM_BYTES  = axi_rd_pkg::DEF_MEM_BYTES
) (
	input  wire                                   clk,
	input  wire                                   resetn,
	// User command
	input  wire                                   cmd_valid,
	output logic                                  cmd_ready,
	input  wire [axi_rd_pkg::ADDR_WIDTH-1:0]      cmd_addr,
	input  wire [axi_rd_pkg::ID_WIDTH-1:0]        cmd_id,
	input  wire [axi_rd_pkg::LEN_WIDTH-1:0]       cmd_len,
	input  wire [axi_rd_pkg::SIZE_WIDTH-1:0]      cmd_size,
	input  wire axi_rd_pkg::burst_e               cmd_burst,
	output logic                                  done,
	// AXI read address
	output logic                                  arvalid,
	input  wire                                   arready,
	output logic [axi_rd_pkg::ADDR_WIDTH-1:0]     araddr,
	output logic [axi_rd_pkg::ID_WIDTH-1:0]       arid,
	output logic [axi_rd_pkg::LEN_WIDTH-1:0]      arlen,
	output logic [axi_rd_pkg::SIZE_WIDTH-1:0]     arsize,
	output axi_rd_pkg::burst_e                    arburst,
	// AXI read data
	input  wire                                   rvalid,
	output logic                                  rready,
	input  wire [DATA_WIDTH-1:0]                  rdata,
	input  wire                                   rlast,
	// Local memory readback
	input  wire [$clog2(MEM_BYTES)-1:0]           mem_rd_addr,
	output logic [7:0]                            mem_rd_data
);

	localparam int MEM_AW = $clog2(MEM_BYTES);

	logic                                 burst_active;
	logic                                 beat_fire;
	logic                                 last_fire;
	logic [axi_rd_pkg::LEN_WIDTH-1:0]     cur_len;
	logic [axi_rd_pkg::SIZE_WIDTH-1:0]    cur_size;
	axi_rd_pkg::burst_e                   cur_burst;
	logic [MEM_AW-1:0]                    beat_addr;
	logic                                 wr_en;
	logic [MEM_AW-1:0]                    wr_addr;
	logic [31:0]                          wr_data;
	logic [2:0]                           wr_bytes;

	ar_channel u_ar_channel (
		.clk          (clk),
		.resetn       (resetn),
		.cmd_valid    (cmd_valid),
		.cmd_addr     (cmd_addr),
		.cmd_id       (cmd_id),
		.cmd_len      (cmd_len),
		.cmd_size     (cmd_size),
		.cmd_burst    (cmd_burst),
		.arready      (arready),
		.last_fire    (last_fire),
		.cmd_ready    (cmd_ready),
		.arvalid      (arvalid),
		.araddr       (araddr),
		.arid         (arid),
		.arlen        (arlen),
		.arsize       (arsize),
		.arburst      (arburst),
		.burst_active (burst_active),
		.done         (done),
		.cur_len      (cur_len),
		.cur_size     (cur_size),
		.cur_burst    (cur_burst)
	);

	beat_addr_gen #(
		.MEM_BYTES (MEM_BYTES)
	) u_beat_addr_gen (
		.clk       (clk),
		.resetn    (resetn),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd_addr  (cmd_addr),
		.cur_len   (cur_len),
		.cur_size  (cur_size),
		.cur_burst (cur_burst),
		.beat_fire (beat_fire),
		.beat_addr (beat_addr)
	);

	r_beat_writer #(
		.DATA_WIDTH (DATA_WIDTH),
		.MEM_BYTES  (MEM_BYTES)
	) u_r_beat_writer (
		.clk          (clk),
		.resetn       (resetn),
		.burst_active (burst_active),
		.rvalid       (rvalid),
		.rdata        (rdata),
		.rlast        (rlast),
		.beat_addr    (beat_addr),
		.cur_size     (cur_size),
		.rready       (rready),
		.beat_fire    (beat_fire),
		.last_fire    (last_fire),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.wr_bytes     (wr_bytes)
	);

	local_byte_ram #(
		.MEM_BYTES (MEM_BYTES)
	) u_local_byte_ram (
		.clk         (clk),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.wr_bytes    (wr_bytes),
		.mem_rd_addr (mem_rd_addr),
		.mem_rd_data (mem_rd_data)
	);

endmodule

`default_nettype wire

/* source/local_byte_ram.sv */
`default_nettype none

module local_byte_ram #(
	parameter int MEM_BYTES = axi_rd_pkg::DEF_MEM_BYTES
) (
	input  wire                          clk,
	input  wire                          wr_en,
	input  wire [$clog2(MEM_BYTES)-1:0]  wr_addr,
	input  wire [31:0]                   wr_data,
	input  wire [2:0]                    wr_bytes,
	input  wire [$clog2(MEM_BYTES)-1:0]  mem_rd_addr,
	output logic [7:0]                   mem_rd_data
);

	localparam int MEM_AW = $clog2(MEM_BYTES);

	logic [7:0] mem [MEM_BYTES];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int i = 0; i < 4; i++) begin
				// Only as many consecutive bytes as the beat carries
				if (i < wr_bytes)
					mem[MEM_AW'(wr_addr + i)] <= wr_data[8*i +: 8];
			end
		end
	end

	// Registered read with one cycle of latency
	always_ff @(posedge clk) begin
		mem_rd_data <= mem[mem_rd_addr];
	end

endmodule

`default_nettype wire

/* source/r_beat_writer.sv */
`default_nettype none

module r_beat_writer #(
	parameter int DATA_WIDTH = axi_rd_pkg::DEF_DATA_WIDTH,
	parameter int MEM_BYTES  = axi_rd_pkg::DEF_MEM_BYTES
) (
	input  wire                                   clk,
	input  wire                                   resetn,
	input  wire                                   burst_active,
	input  wire                                   rvalid,
	input  wire [DATA_WIDTH-1:0]                  rdata,
	input  wire                                   rlast,
	input  wire [$clog2(MEM_BYTES)-1:0]           beat_addr,
	input  wire [axi_rd_pkg::SIZE_WIDTH-1:0]      cur_size,
	output logic                                  rready,
	output logic                                  beat_fire,
	output logic                                  last_fire,
	output logic                                  wr_en,
	output logic [$clog2(MEM_BYTES)-1:0]          wr_addr,
	output logic [31:0]                           wr_data,
	output logic [2:0]                            wr_bytes
);

	assign rready    = burst_active;
	assign beat_fire = rvalid && rready;
	assign last_fire = beat_fire && rlast;

	assign wr_en   = beat_fire;
	assign wr_addr = beat_addr;

	// Byte 0 of the low lanes lands at the beat address
	always_comb begin
		wr_data = '0;
		case (cur_size)
			3'd0: begin
				wr_bytes     = 3'd1;
				wr_data[7:0] = rdata[7:0];
			end
			3'd1: begin
				wr_bytes      = 3'd2;
				wr_data[15:0] = rdata[15:0];
			end
			default: begin
				wr_bytes = 3'd4;
				wr_data  = rdata[31:0];
			end
		endcase
	end

endmodule

`default_nettype wire

/* source/beat_addr_gen.sv */
`default_nettype none

module beat_addr_gen #(
	parameter int MEM_BYTES = axi_rd_pkg::DEF_MEM_BYTES
) (
	input  wire                                   clk,
	input  wire                                   resetn,
	input  wire                                   cmd_valid,
	input  wire                                   cmd_ready,
	input  wire [axi_rd_pkg::ADDR_WIDTH-1:0]      cmd_addr,
	input  wire [axi_rd_pkg::LEN_WIDTH-1:0]       cur_len,
	input  wire [axi_rd_pkg::SIZE_WIDTH-1:0]      cur_size,
	input  wire axi_rd_pkg::burst_e               cur_burst,
	input  wire                                   beat_fire,
	output logic [$clog2(MEM_BYTES)-1:0]          beat_addr
);

	localparam int MEM_AW = $clog2(MEM_BYTES);

	logic [MEM_AW:0]   step;
	logic [MEM_AW:0]   wrap_bound;
	logic [MEM_AW:0]   incr_addr;
	logic [MEM_AW-1:0] next_addr;

	// Bytes per beat and bytes per whole burst
	assign step       = (MEM_AW+1)'(1) << cur_size;
	assign wrap_bound = ((MEM_AW+1)'(cur_len) + 1'b1) << cur_size;

	assign incr_addr = {1'b0, beat_addr} + step;

	always_comb begin
		case (cur_burst)
			axi_rd_pkg::FIXED: begin
				next_addr = beat_addr;
			end
			axi_rd_pkg::WRAP: begin
				// Legal WRAP lengths make the boundary a power of two
				if ((incr_addr & (wrap_bound - 1'b1)) == '0)
					next_addr = MEM_AW'(incr_addr - wrap_bound);
				else
					next_addr = incr_addr[MEM_AW-1:0];
			end
			default: begin
				next_addr = incr_addr[MEM_AW-1:0];
			end
		endcase
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			beat_addr <= '0;
		end else if (cmd_valid && cmd_ready) begin
			beat_addr <= cmd_addr[MEM_AW-1:0];
		end else if (beat_fire) begin
			beat_addr <= next_addr;
		end
	end

endmodule

`default_nettype wire

/* source/ar_channel.sv */
`default_nettype none

module ar_channel (
	input  wire                                   clk,
	input  wire                                   resetn,
	input  wire                                   cmd_valid,
	input  wire [axi_rd_pkg::ADDR_WIDTH-1:0]      cmd_addr,
	input  wire [axi_rd_pkg::ID_WIDTH-1:0]        cmd_id,
	input  wire [axi_rd_pkg::LEN_WIDTH-1:0]       cmd_len,
	input  wire [axi_rd_pkg::SIZE_WIDTH-1:0]      cmd_size,
	input  wire axi_rd_pkg::burst_e               cmd_burst,
	input  wire                                   arready,
	input  wire                                   last_fire,
	output logic                                  cmd_ready,
	output logic                                  arvalid,
	output logic [axi_rd_pkg::ADDR_WIDTH-1:0]     araddr,
	output logic [axi_rd_pkg::ID_WIDTH-1:0]       arid,
	output logic [axi_rd_pkg::LEN_WIDTH-1:0]      arlen,
	output logic [axi_rd_pkg::SIZE_WIDTH-1:0]     arsize,
	output axi_rd_pkg::burst_e                    arburst,
	output logic                                  burst_active,
	output logic                                  done,
	output logic [axi_rd_pkg::LEN_WIDTH-1:0]      cur_len,
	output logic [axi_rd_pkg::SIZE_WIDTH-1:0]     cur_size,
	output axi_rd_pkg::burst_e                    cur_burst
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_DATA
	} state_e;

	state_e state;

	assign cmd_ready    = (state == ST_IDLE);
	assign arvalid      = (state == ST_ADDR);
	assign burst_active = (state == ST_DATA);

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state <= ST_IDLE;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (cmd_valid)
						state <= ST_ADDR;
				end
				ST_ADDR: begin
					if (arready)
						state <= ST_DATA;
				end
				default: begin
					if (last_fire) begin
						state <= ST_IDLE;
						done  <= 1'b1;
					end
				end
			endcase
		end
	end

	// Command held from acceptance until the next one
	always_ff @(posedge clk) begin
		if (cmd_valid && cmd_ready) begin
			araddr  <= cmd_addr;
			arid    <= cmd_id;
			arlen   <= cmd_len;
			arsize  <= cmd_size;
			arburst <= cmd_burst;
		end
	end

	assign cur_len   = arlen;
	assign cur_size  = arsize;
	assign cur_burst = arburst;

endmodule

`default_nettype wire

/* source/axi_rd_pkg.sv */
`default_nettype none

package axi_rd_pkg;

	// AXI burst encodings
	typedef enum logic [1:0] {
		FIXED = 2'd0,
		INCR  = 2'd1,
		WRAP  = 2'd2
	} burst_e;

	localparam int ADDR_WIDTH = 32;
	localparam int ID_WIDTH   = 4;

	// Beats minus one, so up to 16 beats
	localparam int LEN_WIDTH  = 4;

	// Bytes per beat is two to the power of size
	localparam int SIZE_WIDTH = 3;

	localparam int DEF_DATA_WIDTH = 32;
	localparam int DEF_MEM_BYTES  = 4096;

endpackage

`default_nettype wire
